// ==== compile.f ====
hdl/bufctrl_pkg.sv
hdl/acl_tx_buffer.sv
hdl/sco_tx_buffer.sv
hdl/tx_slot_select.sv
hdl/bufctrl.sv
sim/bufctrl_props.sv
sim/bufctrl_tb.sv

// ==== hdl/acl_tx_buffer.sv ====
`timescale 1ns/1ps

module acl_tx_buffer (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] bsm_addr,
  input  logic [bufctrl_pkg::word_w-1:0]     bsm_din,
  input  logic                              bsm_we,
  input  logic                              bsm_cs,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] lnctrl_addr,
  input  logic [bufctrl_pkg::lt_addr_w-1:0]  ms_lt_addr,
  input  logic [bufctrl_pkg::num_lt-1:0]     dec_arqn,
  input  logic [bufctrl_pkg::num_lt-1:0]     dec_flow,
  input  logic                              py_endp,
  input  logic                              header_st_p,
  input  logic                              pk_encode,
  output logic [bufctrl_pkg::word_w-1:0]     lnctrl_dout
);

  import bufctrl_pkg::*;

  // Both banks in one array with the bank flag on top
  logic [word_w-1:0]   mem [0:2*(2**buf_addr_w)-1];
  logic                acl_bank;   // Bank currently on air
  logic [buf_addr_w:0] wr_addr;
  logic [buf_addr_w:0] rd_addr;
  logic                ack_p;
  logic                stop_p;

  // ACK for this transport means the peer has the payload
  assign ack_p  = py_endp & dec_arqn[ms_lt_addr];

  // FLOW=STOP at a new header resends the old payload
  assign stop_p = header_st_p & pk_encode & ~dec_flow[ms_lt_addr];

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      acl_bank <= 1'b0;
    else if (ack_p || stop_p)
      acl_bank <= ~acl_bank;
  end

  // Host fills the idle bank
  assign wr_addr = {~acl_bank, bsm_addr};
  assign rd_addr = {acl_bank, lnctrl_addr};

  always_ff @(posedge clk_6M)
  begin
    if (bsm_cs && bsm_we)
      mem[wr_addr] <= bsm_din;
  end

  assign lnctrl_dout = mem[rd_addr];   // Async read

endmodule

// ==== hdl/bufctrl.sv ====
`timescale 1ns/1ps

module bufctrl (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic                              header_st_p,
  input  logic                              pk_encode,
  input  logic                              py_endp,
  input  logic [bufctrl_pkg::lt_addr_w-1:0]  ms_lt_addr,
  input  logic [bufctrl_pkg::num_lt-1:0]     dec_arqn,
  input  logic [bufctrl_pkg::num_lt-1:0]     dec_flow,
  input  logic                              ms_tslot_p,
  input  logic [bufctrl_pkg::bitcount_w-1:0] pybitcount,
  input  logic                              lmp_cmd_p,
  input  logic                              py_datperiod,
  input  logic                              tx_reservedslot,
  input  logic                              txtsco_p,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] acl_bsm_addr,
  input  logic [bufctrl_pkg::word_w-1:0]     acl_bsm_din,
  input  logic                              acl_bsm_we,
  input  logic                              acl_bsm_cs,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] sco_bsm_addr,
  input  logic [bufctrl_pkg::word_w-1:0]     sco_bsm_din,
  input  logic                              sco_bsm_we,
  input  logic                              sco_bsm_cs,
  output logic                              lnctrl_txpybitin
);

  import bufctrl_pkg::*;

  logic [buf_addr_w-1:0] word_addr;
  logic [bit_sel_w-1:0]  bit_sel;
  logic [word_w-1:0]     acl_word;
  logic [word_w-1:0]     sco_word;

  // Upper bits pick the word, lower bits the bit within it
  assign word_addr = pybitcount[bitcount_w-1:bit_sel_w];
  assign bit_sel   = pybitcount[bit_sel_w-1:0];

  acl_tx_buffer acl_tx_buffer_i (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .bsm_addr    (acl_bsm_addr),
    .bsm_din     (acl_bsm_din),
    .bsm_we      (acl_bsm_we),
    .bsm_cs      (acl_bsm_cs),
    .lnctrl_addr (word_addr),
    .ms_lt_addr  (ms_lt_addr),
    .dec_arqn    (dec_arqn),
    .dec_flow    (dec_flow),
    .py_endp     (py_endp),
    .header_st_p (header_st_p),
    .pk_encode   (pk_encode),
    .lnctrl_dout (acl_word)
  );

  sco_tx_buffer sco_tx_buffer_i (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .tsco_p      (txtsco_p),
    .bsm_addr    (sco_bsm_addr),
    .bsm_din     (sco_bsm_din),
    .bsm_we      (sco_bsm_we),
    .bsm_cs      (sco_bsm_cs),
    .lnctrl_addr (word_addr),
    .lnctrl_dout (sco_word)
  );

  tx_slot_select tx_slot_select_i (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .lmp_cmd_p        (lmp_cmd_p),
    .ms_tslot_p       (ms_tslot_p),
    .py_datperiod     (py_datperiod),
    .tx_reservedslot  (tx_reservedslot),
    .bit_sel          (bit_sel),
    .acl_word         (acl_word),
    .sco_word         (sco_word),
    .lnctrl_txpybitin (lnctrl_txpybitin)
  );

endmodule

// ==== hdl/bufctrl_pkg.sv ====
package bufctrl_pkg;

  // Buffer geometry
  localparam int buf_addr_w = 8;   // 256 words per bank
  localparam int word_w     = 32;
  localparam int bit_sel_w  = 5;

  // Payload bit counter, word address over bit index
  localparam int bitcount_w = buf_addr_w + bit_sel_w;

  // Logical transports
  localparam int lt_addr_w  = 3;
  localparam int num_lt     = 8;

endpackage

// ==== hdl/sco_tx_buffer.sv ====
`timescale 1ns/1ps

module sco_tx_buffer (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic                              tsco_p,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] bsm_addr,
  input  logic [bufctrl_pkg::word_w-1:0]     bsm_din,
  input  logic                              bsm_we,
  input  logic                              bsm_cs,
  input  logic [bufctrl_pkg::buf_addr_w-1:0] lnctrl_addr,
  output logic [bufctrl_pkg::word_w-1:0]     lnctrl_dout
);

  import bufctrl_pkg::*;

  logic [word_w-1:0]   mem [0:2*(2**buf_addr_w)-1];
  logic                sco_bank;
  logic [buf_addr_w:0] wr_addr;
  logic [buf_addr_w:0] rd_addr;

  // Voice is never resent, swap every interval
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      sco_bank <= 1'b0;
    else if (tsco_p)
      sco_bank <= ~sco_bank;
  end

  assign wr_addr = {~sco_bank, bsm_addr};   // Idle bank
  assign rd_addr = {sco_bank, lnctrl_addr};

  always_ff @(posedge clk_6M)
  begin
    if (bsm_cs && bsm_we)
      mem[wr_addr] <= bsm_din;
  end

  assign lnctrl_dout = mem[rd_addr];

endmodule

// ==== hdl/tx_slot_select.sv ====
`timescale 1ns/1ps

module tx_slot_select (
  input  logic                             clk_6M,
  input  logic                             rstz,
  input  logic                             lmp_cmd_p,
  input  logic                             ms_tslot_p,
  input  logic                             py_datperiod,
  input  logic                             tx_reservedslot,
  input  logic [bufctrl_pkg::bit_sel_w-1:0] bit_sel,
  input  logic [bufctrl_pkg::word_w-1:0]    acl_word,
  input  logic [bufctrl_pkg::word_w-1:0]    sco_word,
  output logic                             lnctrl_txpybitin
);

  import bufctrl_pkg::*;

  logic              lmp_pending;
  logic              lmp_slot;
  logic              acl_sel;
  logic              sco_sel;
  logic [word_w-1:0] tx_word;

  // Command waits here for the next slot boundary
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lmp_pending <= 1'b0;
    else if (lmp_cmd_p)
      lmp_pending <= 1'b1;
    else if (ms_tslot_p)
      lmp_pending <= 1'b0;
  end

  // LMP owns one slot only
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lmp_slot <= 1'b0;
    else if (ms_tslot_p)
      lmp_slot <= lmp_pending;
  end

  // LMP rides on ACL even inside a reserved slot
  assign acl_sel = py_datperiod & (lmp_slot | ~tx_reservedslot);
  assign sco_sel = py_datperiod & ~lmp_slot & tx_reservedslot;

  assign tx_word = ({word_w{acl_sel}} & acl_word) |
                   ({word_w{sco_sel}} & sco_word);

  assign lnctrl_txpybitin = tx_word[bit_sel];   // Zero outside payload

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bufctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  --top-module bufctrl_tb \
  -f compile.f \
  -Mdir "$OBJ" -o bufctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/bufctrl_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL"
  exit 1
fi

// ==== sim/bufctrl_props.sv ====
`timescale 1ns/1ps

module bufctrl_props (
  input logic clk_6M,
  input logic rstz,
  input logic sel_a,
  input logic sel_b,
  input logic flag,
  input logic flag_event
);

  // Only one source on the payload bit
  sel_exclusive: assert property (@(posedge clk_6M) disable iff (!rstz)
    !(sel_a && sel_b))
    else $error("%m both data selects high");

  // State flag moves only on its own pulse
  flag_on_event: assert property (@(posedge clk_6M) disable iff (!rstz)
    !flag_event |=> $stable(flag))
    else $error("%m flag changed without its event");

endmodule

bind tx_slot_select bufctrl_props slot_props_i (
  .clk_6M     (clk_6M),
  .rstz       (rstz),
  .sel_a      (acl_sel),
  .sel_b      (sco_sel),
  .flag       (lmp_slot),
  .flag_event (ms_tslot_p)
);

bind acl_tx_buffer bufctrl_props bank_props_i (
  .clk_6M     (clk_6M),
  .rstz       (rstz),
  .sel_a      (1'b0),
  .sel_b      (1'b0),
  .flag       (acl_bank),
  .flag_event (py_endp | header_st_p)
);

// ==== sim/bufctrl_tb.sv ====
`timescale 1ns/1ps

module bufctrl_tb;

  import bufctrl_pkg::*;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 3;
  localparam int idle_cycles  = 10;
  localparam int fill_words   = 2**buf_addr_w;
  localparam int sweep_cycles = 2**bitcount_w;
  localparam int sco_cycles   = 1000;
  localparam int acl_cycles   = 1000;
  localparam int lmp_rounds   = 5;
  localparam int lmp_round_len = 48;
  localparam int mix_cycles   = 2000;
  localparam int total_cycles = reset_cycles + idle_cycles + 2 * fill_words + 1 +
                                sweep_cycles + sco_cycles + acl_cycles +
                                lmp_rounds * lmp_round_len + mix_cycles;
  localparam int timeout_ns   = (total_cycles + 500) * clk_period;

  logic clk_6M = 1'b0;
  logic rstz;
  logic header_st_p, pk_encode, py_endp;
  logic [lt_addr_w-1:0]  ms_lt_addr;
  logic [num_lt-1:0]     dec_arqn, dec_flow;
  logic ms_tslot_p, lmp_cmd_p, py_datperiod, tx_reservedslot, txtsco_p;
  logic [bitcount_w-1:0] pybitcount;
  logic [buf_addr_w-1:0] acl_bsm_addr, sco_bsm_addr;
  logic [word_w-1:0]     acl_bsm_din, sco_bsm_din;
  logic acl_bsm_we, acl_bsm_cs, sco_bsm_we, sco_bsm_cs;
  logic lnctrl_txpybitin;

  integer seed;

  // Shadow stores, bank flag is the top index bit
  logic [word_w-1:0] acl_m [0:2*fill_words-1];
  logic [word_w-1:0] sco_m [0:2*fill_words-1];
  logic model_acl_bank, model_sco_bank, model_lmp_pending, model_lmp_slot;

  always #(clk_period/2) clk_6M = ~clk_6M;

  bufctrl bufctrl_i (
    .clk_6M (clk_6M), .rstz (rstz),
    .header_st_p (header_st_p), .pk_encode (pk_encode), .py_endp (py_endp),
    .ms_lt_addr (ms_lt_addr), .dec_arqn (dec_arqn), .dec_flow (dec_flow),
    .ms_tslot_p (ms_tslot_p), .pybitcount (pybitcount), .lmp_cmd_p (lmp_cmd_p),
    .py_datperiod (py_datperiod), .tx_reservedslot (tx_reservedslot),
    .txtsco_p (txtsco_p),
    .acl_bsm_addr (acl_bsm_addr), .acl_bsm_din (acl_bsm_din),
    .acl_bsm_we (acl_bsm_we), .acl_bsm_cs (acl_bsm_cs),
    .sco_bsm_addr (sco_bsm_addr), .sco_bsm_din (sco_bsm_din),
    .sco_bsm_we (sco_bsm_we), .sco_bsm_cs (sco_bsm_cs),
    .lnctrl_txpybitin (lnctrl_txpybitin)
  );

  function logic [31:0] rand32();
    return $random(seed);
  endfunction

  task check_value(input string name, input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
    begin
      $display("[ERROR] %0t ns %s: expected %b, got %b", $time, name, exp_val, act_val);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // Model state change at a rising edge, writes see the old bank
  task apply_edge();
    if (acl_bsm_cs && acl_bsm_we)
      acl_m[{~model_acl_bank, acl_bsm_addr}] = acl_bsm_din;
    if (sco_bsm_cs && sco_bsm_we)
      sco_m[{~model_sco_bank, sco_bsm_addr}] = sco_bsm_din;
    if (py_endp && dec_arqn[ms_lt_addr])
      model_acl_bank = ~model_acl_bank;   // ACK, next payload
    else if (header_st_p && pk_encode && !dec_flow[ms_lt_addr])
      model_acl_bank = ~model_acl_bank;   // STOP, back to old payload
    if (txtsco_p)
      model_sco_bank = ~model_sco_bank;
    if (ms_tslot_p)
      model_lmp_slot = model_lmp_pending;
    if (lmp_cmd_p)
      model_lmp_pending = 1'b1;
    else if (ms_tslot_p)
      model_lmp_pending = 1'b0;
  endtask

  function logic expected_bit();
    logic [buf_addr_w-1:0] wa;
    logic [bit_sel_w-1:0]  bs;
    wa = pybitcount[bitcount_w-1:bit_sel_w];
    bs = pybitcount[bit_sel_w-1:0];
    if (!py_datperiod)
      return 1'b0;
    if (model_lmp_slot || !tx_reservedslot)
      return acl_m[{model_acl_bank, wa}][bs];
    return sco_m[{model_sco_bank, wa}][bs];
  endfunction

  // Edge, model update, then pulses and strobes back to idle
  task next_cycle();
    @(posedge clk_6M);
    apply_edge();
    #1;
    header_st_p = 1'b0;
    py_endp     = 1'b0;
    ms_tslot_p  = 1'b0;
    lmp_cmd_p   = 1'b0;
    txtsco_p    = 1'b0;
    acl_bsm_we  = 1'b0;
    acl_bsm_cs  = 1'b0;
    sco_bsm_we  = 1'b0;
    sco_bsm_cs  = 1'b0;
  endtask

  task settle_and_check();
    #2;
    check_value("lnctrl_txpybitin", expected_bit(), lnctrl_txpybitin);
  endtask

  task random_writes();
    logic [31:0] r;
    r = rand32();
    acl_bsm_cs   = r[0];
    acl_bsm_we   = r[1];
    acl_bsm_addr = r[9:2];
    sco_bsm_cs   = r[10];
    sco_bsm_we   = r[11];
    sco_bsm_addr = r[19:12];
    acl_bsm_din  = rand32();
    sco_bsm_din  = rand32();
  endtask

  task random_transport();
    logic [31:0] r;
    r = rand32();
    dec_arqn   = r[num_lt-1:0];
    dec_flow   = r[2*num_lt-1:num_lt];
    ms_lt_addr = r[2*num_lt+lt_addr_w-1:2*num_lt];
  endtask

  task fill_banks();
    for (int i = 0; i < fill_words; i++)
    begin
      next_cycle();
      acl_bsm_cs   = 1'b1;
      acl_bsm_we   = 1'b1;
      acl_bsm_addr = i[buf_addr_w-1:0];
      acl_bsm_din  = rand32();
      sco_bsm_cs   = 1'b1;
      sco_bsm_we   = 1'b1;
      sco_bsm_addr = i[buf_addr_w-1:0];
      sco_bsm_din  = rand32();
      settle_and_check();
    end
  endtask

  task slot_cycle(input logic cmd, input logic tslot);
    logic [31:0] r;
    next_cycle();
    r = rand32();
    lmp_cmd_p  = cmd;
    ms_tslot_p = tslot;
    pybitcount = r[bitcount_w-1:0];
    random_writes();
    settle_and_check();
  endtask

  task mix_cycle();
    logic [31:0] r;
    next_cycle();
    r = rand32();
    py_datperiod = (r[2:0] != 3'd0);
    if (r[7:3] == 5'd0)
      tx_reservedslot = ~tx_reservedslot;
    py_endp     = (r[10:8] == 3'd0);
    header_st_p = (r[13:11] == 3'd0);
    pk_encode   = r[14];
    ms_tslot_p  = (r[18:15] == 4'd0);
    lmp_cmd_p   = (r[22:19] == 4'd0);
    txtsco_p    = (r[26:23] == 4'd0);
    if (r[29:27] == 3'd0)
      random_transport();
    r = rand32();
    pybitcount = r[bitcount_w-1:0];
    random_writes();
    settle_and_check();
  endtask

  initial
  begin
    #(timeout_ns);
    $display("Run timed out after %0d ns before all tests finished", timeout_ns);
    $display("Something failed");
    $fatal(1);
  end

  initial
  begin
    logic [31:0] r;
    seed = 80;
    rstz = 1'b0;
    header_st_p = 1'b0;
    pk_encode = 1'b0;
    py_endp = 1'b0;
    ms_lt_addr = '0;
    dec_arqn = '0;
    dec_flow = '1;
    ms_tslot_p = 1'b0;
    lmp_cmd_p = 1'b0;
    py_datperiod = 1'b0;
    tx_reservedslot = 1'b0;
    txtsco_p = 1'b0;
    pybitcount = '0;
    acl_bsm_addr = '0;
    acl_bsm_din = '0;
    acl_bsm_we = 1'b0;
    acl_bsm_cs = 1'b0;
    sco_bsm_addr = '0;
    sco_bsm_din = '0;
    sco_bsm_we = 1'b0;
    sco_bsm_cs = 1'b0;
    model_acl_bank = 1'b0;
    model_sco_bank = 1'b0;
    model_lmp_pending = 1'b0;
    model_lmp_slot = 1'b0;
    repeat (reset_cycles) @(posedge clk_6M);
    #1;
    rstz = 1'b1;

    repeat (idle_cycles)   // No payload period, output held low
    begin
      next_cycle();
      r = rand32();
      pybitcount = r[bitcount_w-1:0];
      settle_and_check();
    end

    // Fill both banks of both stores
    fill_banks();
    next_cycle();
    py_endp  = 1'b1;
    dec_arqn = '1;
    txtsco_p = 1'b1;
    settle_and_check();
    fill_banks();

    py_datperiod = 1'b1;
    for (int i = 0; i < sweep_cycles; i++)
    begin
      next_cycle();
      pybitcount = i[bitcount_w-1:0];
      random_writes();
      settle_and_check();
    end

    tx_reservedslot = 1'b1;
    repeat (sco_cycles)
    begin
      next_cycle();
      r = rand32();
      txtsco_p   = (r[3:0] == 4'd0);
      pybitcount = r[bitcount_w+3:4];
      random_writes();
      settle_and_check();
    end

    tx_reservedslot = 1'b0;
    repeat (acl_cycles)
    begin
      next_cycle();
      r = rand32();
      py_endp     = (r[2:0] == 3'd0);
      header_st_p = (r[5:3] == 3'd0);
      pk_encode   = r[6];
      pybitcount  = r[bitcount_w+6:7];
      if (r[22:20] == 3'd0)
        random_transport();
      random_writes();
      settle_and_check();
    end

    tx_reservedslot = 1'b1;
    repeat (lmp_rounds)
    begin
      repeat (5) slot_cycle(1'b0, 1'b0);
      slot_cycle(1'b1, 1'b0);
      repeat (5) slot_cycle(1'b0, 1'b0);
      slot_cycle(1'b0, 1'b1);    // LMP slot starts
      repeat (20) slot_cycle(1'b0, 1'b0);
      slot_cycle(1'b0, 1'b1);    // Back to SCO
      repeat (15) slot_cycle(1'b0, 1'b0);
    end

    repeat (mix_cycles) mix_cycle();

    $display("Everything OK");
    $finish;
  end

endmodule
